/* hw/pipe_trace_pkg.sv */
//////////////////////////////
// pipe trace package
// widths, depths and record types for the pipeline trace monitor
//////////////////////////////
`default_nettype none

package pipe_trace_pkg;

    // one store entry per tag, tags wrap at the depth
    localparam int TRACE_DEPTH = 16;
    localparam int TAG_W       = $clog2(TRACE_DEPTH);
    // free-running cycle count
    localparam int CYCLE_W     = 32;
    // saturating stall counters
    localparam int STALL_W     = 8;
    localparam int ADDR_W      = 32;
    localparam int INSN_W      = 32;

    typedef logic [TAG_W-1:0] trace_tag_t;

    // occupancy of one pipeline stage
    typedef struct packed {
        logic       valid;
        trace_tag_t tag;
    } stage_slot_t;

    // known when the instruction enters fetch
    typedef struct packed {
        logic [ADDR_W-1:0]  addr;
        logic [CYCLE_W-1:0] fetch_cycle;
    } fetch_rec_t;

    // word captured as the instruction leaves decode
    typedef struct packed {
        logic [INSN_W-1:0] insn;
    } decode_rec_t;

    typedef struct packed {
        logic [STALL_W-1:0] fetch_stalls;
        logic [STALL_W-1:0] decode_stalls;
    } stall_rec_t;

    // one record per retired instruction
    typedef struct packed {
        trace_tag_t         tag;
        logic [ADDR_W-1:0]  addr;
        logic [INSN_W-1:0]  insn;
        logic [CYCLE_W-1:0] fetch_cycle;
        logic [CYCLE_W-1:0] retire_cycle;
        logic [STALL_W-1:0] fetch_stalls;
        logic [STALL_W-1:0] decode_stalls;
    } retire_rec_t;

endpackage

`default_nettype wire

/* hw/stage_tag_pipe.sv */
//////////////////////////////
// stage tag pipe
// hands out wrapping trace tags and moves them
// through the five stages under stall and flush
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module stage_tag_pipe (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        fetch_valid,
    input  logic                        stall,
    input  logic                        flush,
    output pipe_trace_pkg::stage_slot_t slot_if,
    output pipe_trace_pkg::stage_slot_t slot_id,
    output pipe_trace_pkg::stage_slot_t slot_ex,
    output pipe_trace_pkg::stage_slot_t slot_mem,
    output pipe_trace_pkg::stage_slot_t slot_wb,
    output logic                        fetch_enter,
    output pipe_trace_pkg::trace_tag_t  enter_tag,
    output logic                        decode_adv,
    output logic                        hold
);
    import pipe_trace_pkg::*;

    // next tag to hand out
    trace_tag_t  tag_q;
    stage_slot_t all_slots [5];
    logic        dup_tag;

    // new instruction accepted at the coming edge, carrying tag_q
    assign fetch_enter = fetch_valid && !stall && !flush;
    assign enter_tag   = tag_q;
    assign decode_adv  = slot_id.valid && !stall && !flush;
    // flush beats stall
    assign hold        = stall && !flush;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tag_q    <= '0;
            slot_if  <= '0;
            slot_id  <= '0;
            slot_ex  <= '0;
            slot_mem <= '0;
            slot_wb  <= '0;
        end else begin
            // back end never stalls
            slot_mem <= slot_ex;
            slot_wb  <= slot_mem;
            if (flush) begin
                slot_if <= '0;
                slot_id <= '0;
                slot_ex <= '0;
            end else if (stall) begin
                // front end holds, bubble into execute
                slot_ex <= '0;
            end else begin
                slot_ex <= slot_id;
                slot_id <= slot_if;
                if (fetch_valid) begin
                    slot_if <= '{valid: 1'b1, tag: tag_q};
                    // wraps modulo TRACE_DEPTH
                    tag_q   <= tag_q + 1'b1;
                end else begin
                    slot_if <= '0;
                end
            end
        end
    end

    ////////////////////////////////
    // checks
    ////////////////////////////////
    assign all_slots = '{slot_if, slot_id, slot_ex, slot_mem, slot_wb};

    always_comb begin
        dup_tag = 1'b0;
        for (int i = 0; i < 5; i++) begin
            for (int j = i + 1; j < 5; j++) begin
                if (all_slots[i].valid && all_slots[j].valid &&
                    all_slots[i].tag == all_slots[j].tag) begin
                    dup_tag = 1'b1;
                end
            end
        end
    end

    // a live tag must never be handed out twice
    a_unique_tags: assert property (@(posedge clk) disable iff (rst) !dup_tag);
    // a held front end feeds a bubble to execute
    a_hold_bubble: assert property (@(posedge clk) disable iff (rst) hold |=> !slot_ex.valid);

endmodule

`default_nettype wire

/* hw/stall_tally.sv */
//////////////////////////////
// stall tally
// per-tag fetch and decode stall counters
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module stall_tally (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        fetch_enter,
    input  pipe_trace_pkg::trace_tag_t  enter_tag,
    input  logic                        hold,
    input  pipe_trace_pkg::stage_slot_t slot_if,
    input  pipe_trace_pkg::stage_slot_t slot_id,
    input  pipe_trace_pkg::trace_tag_t  rd_tag,
    output pipe_trace_pkg::stall_rec_t  rd_stall
);
    import pipe_trace_pkg::*;

    // one pair of counters per tag
    stall_rec_t tally [TRACE_DEPTH];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < TRACE_DEPTH; i++) begin
                tally[i] <= '0;
            end
        end else if (fetch_enter) begin
            // fresh instruction starts from zero
            tally[enter_tag] <= '0;
        end else if (hold) begin
            // enter needs a free front end, so it never meets hold
            if (slot_if.valid && !(&tally[slot_if.tag].fetch_stalls)) begin
                tally[slot_if.tag].fetch_stalls <=
                    tally[slot_if.tag].fetch_stalls + 1'b1;
            end
            // saturate instead of wrapping
            if (slot_id.valid && !(&tally[slot_id.tag].decode_stalls)) begin
                tally[slot_id.tag].decode_stalls <=
                    tally[slot_id.tag].decode_stalls + 1'b1;
            end
        end
    end

    // counts settle once the tag leaves decode
    assign rd_stall = tally[rd_tag];

endmodule

`default_nettype wire

/* hw/trace_ram.sv */
//////////////////////////////
// trace ram
// tag-indexed store, edge write, async read
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module trace_ram #(
    parameter type entry_t = logic [31:0]
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wr_en,
    input  pipe_trace_pkg::trace_tag_t wr_tag,
    input  entry_t                     wr_data,
    input  pipe_trace_pkg::trace_tag_t rd_tag,
    output entry_t                     rd_data
);
    import pipe_trace_pkg::*;

    entry_t mem [TRACE_DEPTH];

    // plain register array
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_tag] <= wr_data;
        end
    end

    assign rd_data = mem[rd_tag];

    // write tag comes from the tag pipe and must be clean
    a_wr_tag_known: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !$isunknown(wr_tag));

endmodule

`default_nettype wire

/* hw/retire_report.sv */
//////////////////////////////
// retire report
// owns the cycle count and registers one
// record per instruction in write-back
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module retire_report (
    input  logic                                clk,
    input  logic                                rst,
    input  pipe_trace_pkg::stage_slot_t         slot_wb,
    input  pipe_trace_pkg::fetch_rec_t          fetch_data,
    input  pipe_trace_pkg::decode_rec_t         decode_data,
    input  pipe_trace_pkg::stall_rec_t          stall_data,
    output logic [pipe_trace_pkg::CYCLE_W-1:0]  cycle,
    output logic                                retire_valid,
    output pipe_trace_pkg::retire_rec_t         retire_rec
);
    import pipe_trace_pkg::*;

    retire_rec_t rec_next;

    ////////////////////////////////
    // cycle count
    ////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1'b1;
        end
    end

    ////////////////////////////////
    // record assembly
    ////////////////////////////////
    // all three stores are read at the write-back tag
    always_comb begin
        rec_next.tag           = slot_wb.tag;
        rec_next.addr          = fetch_data.addr;
        rec_next.insn          = decode_data.insn;
        rec_next.fetch_cycle   = fetch_data.fetch_cycle;
        // count at the edge that loaded write-back, one behind now
        rec_next.retire_cycle  = cycle - 1'b1;
        rec_next.fetch_stalls  = stall_data.fetch_stalls;
        rec_next.decode_stalls = stall_data.decode_stalls;
    end

    // strobe, no back-pressure
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= slot_wb.valid;
        end
    end

    // payload only loads with a valid write-back
    always_ff @(posedge clk) begin
        if (slot_wb.valid) begin
            retire_rec <= rec_next;
        end
    end

endmodule

`default_nettype wire

/* hw/pipe_trace_top.sv */
//////////////////////////////
// pipe trace top
// trace monitor for a five-stage pipeline
// that emits one retire record per completed instruction
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pipe_trace_top (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               fetch_valid,
    input  logic [pipe_trace_pkg::ADDR_W-1:0]  fetch_addr,
    input  logic [pipe_trace_pkg::INSN_W-1:0]  decode_insn,
    input  logic                               stall,
    input  logic                               flush,
    output logic                               retire_valid,
    output pipe_trace_pkg::retire_rec_t        retire_rec
);
    import pipe_trace_pkg::*;

    // stage occupancy
    stage_slot_t        slot_if;
    stage_slot_t        slot_id;
    stage_slot_t        slot_wb;
    logic               fetch_enter;
    trace_tag_t         enter_tag;
    logic               decode_adv;
    logic               hold;
    logic [CYCLE_W-1:0] cycle;

    // store traffic
    fetch_rec_t         fetch_wr;
    fetch_rec_t         fetch_rd;
    decode_rec_t        decode_wr;
    decode_rec_t        decode_rd;
    stall_rec_t         stall_rd;

    assign fetch_wr  = '{addr: fetch_addr, fetch_cycle: cycle};
    assign decode_wr = '{insn: decode_insn};

    stage_tag_pipe u_tag_pipe (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .stall       (stall),
        .flush       (flush),
        .slot_if     (slot_if),
        .slot_id     (slot_id),
        .slot_ex     (),
        .slot_mem    (),
        .slot_wb     (slot_wb),
        .fetch_enter (fetch_enter),
        .enter_tag   (enter_tag),
        .decode_adv  (decode_adv),
        .hold        (hold)
    );

    stall_tally u_tally (
        .clk         (clk),
        .rst         (rst),
        .fetch_enter (fetch_enter),
        .enter_tag   (enter_tag),
        .hold        (hold),
        .slot_if     (slot_if),
        .slot_id     (slot_id),
        .rd_tag      (slot_wb.tag),
        .rd_stall    (stall_rd)
    );

    // address and fetch cycle written on entry
    trace_ram #(.entry_t(fetch_rec_t)) u_fetch_ram (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (fetch_enter),
        .wr_tag  (enter_tag),
        .wr_data (fetch_wr),
        .rd_tag  (slot_wb.tag),
        .rd_data (fetch_rd)
    );

    // instruction word written as decode advances
    trace_ram #(.entry_t(decode_rec_t)) u_decode_ram (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (decode_adv),
        .wr_tag  (slot_id.tag),
        .wr_data (decode_wr),
        .rd_tag  (slot_wb.tag),
        .rd_data (decode_rd)
    );

    retire_report u_report (
        .clk          (clk),
        .rst          (rst),
        .slot_wb      (slot_wb),
        .fetch_data   (fetch_rd),
        .decode_data  (decode_rd),
        .stall_data   (stall_rd),
        .cycle        (cycle),
        .retire_valid (retire_valid),
        .retire_rec   (retire_rec)
    );

endmodule

`default_nettype wire

/* test/trace_model.svh */
//////////////////////////////
// trace model
// reference pipeline with its own slots and
// the queue of retire records still expected
//////////////////////////////
`ifndef TRACE_MODEL_SVH
`define TRACE_MODEL_SVH

// records in fetch, decode, execute and memory
retire_rec_t m_if;
retire_rec_t m_id;
retire_rec_t m_ex;
retire_rec_t m_mem;
logic        m_if_v;
logic        m_id_v;
logic        m_ex_v;
logic        m_mem_v;
// next tag and cycle count as seen at the coming edge
trace_tag_t         m_tag;
logic [CYCLE_W-1:0] m_cycle;
// expected records, oldest first
retire_rec_t        exp_q [$];

function automatic logic [STALL_W-1:0] sat_inc(input logic [STALL_W-1:0] v);
    if (&v) begin
        return v;
    end
    return v + 1'b1;
endfunction

task automatic model_reset();
    m_if_v  = 1'b0;
    m_id_v  = 1'b0;
    m_ex_v  = 1'b0;
    m_mem_v = 1'b0;
    m_tag   = '0;
    m_cycle = '0;
    exp_q.delete();
endtask

// one rising edge with the inputs the DUT samples there
task automatic model_step(input logic fv, input logic [ADDR_W-1:0] addr,
                          input logic [INSN_W-1:0] insn, input logic st, input logic fl);
    retire_rec_t done_rec;
    // memory moves into write-back, its record is now due
    if (m_mem_v) begin
        done_rec              = m_mem;
        done_rec.retire_cycle = m_cycle;
        exp_q.push_back(done_rec);
    end
    m_mem   = m_ex;
    m_mem_v = m_ex_v;
    if (fl) begin
        // front end killed, flush beats stall
        m_if_v = 1'b0;
        m_id_v = 1'b0;
        m_ex_v = 1'b0;
    end else if (st) begin
        if (m_if_v) begin
            m_if.fetch_stalls = sat_inc(m_if.fetch_stalls);
        end
        if (m_id_v) begin
            m_id.decode_stalls = sat_inc(m_id.decode_stalls);
        end
        m_ex_v = 1'b0;
    end else begin
        // word is taken as decode advances
        if (m_id_v) begin
            m_id.insn = insn;
        end
        m_ex   = m_id;
        m_ex_v = m_id_v;
        m_id   = m_if;
        m_id_v = m_if_v;
        if (fv) begin
            m_if             = '0;
            m_if.tag         = m_tag;
            m_if.addr        = addr;
            m_if.fetch_cycle = m_cycle;
            m_if_v           = 1'b1;
            m_tag            = m_tag + 1'b1;
        end else begin
            m_if_v = 1'b0;
        end
    end
    m_cycle = m_cycle + 1'b1;
endtask

`endif

/* test/tb_pipe_trace.sv */
//////////////////////////////
// pipe trace testbench
// random pipeline control against a reference model
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_trace;
    import pipe_trace_pkg::*;

    localparam int RESET_CYCLES   = 16;
    localparam int STIM_CYCLES    = 3000;
    localparam int DRAIN_CYCLES   = 10;
    // whole run plus a margin
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + STIM_CYCLES + DRAIN_CYCLES + 50;

    logic              clk = 1'b0;
    logic              rst;
    logic              fetch_valid;
    logic [ADDR_W-1:0] fetch_addr;
    logic [INSN_W-1:0] decode_insn;
    logic              stall;
    logic              flush;
    logic              retire_valid;
    retire_rec_t       retire_rec;

    logic [31:0] rng;
    int          cycle_count = 0;
    int          errors;
    int          retired;

    `include "trace_model.svh"

    pipe_trace_top uut (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .fetch_addr   (fetch_addr),
        .decode_insn  (decode_insn),
        .stall        (stall),
        .flush        (flush),
        .retire_valid (retire_valid),
        .retire_rec   (retire_rec)
    );

    // 100 ns period
    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("ERROR at %0t: %s got %h, expected %h", $time, what, got, want);
            $display("Done: errors found");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic fail_run(input string why);
        errors++;
        $display("FAILED at %0t: %s", $time, why);
        $display("Done: errors found");
        $fatal(1, "run aborted");
    endtask

    // roughly 80% fetch, 20% stall, 5% flush
    task automatic drive_random();
        rng         = xorshift32(rng);
        fetch_valid = (rng % 32'd100) < 32'd80;
        rng         = xorshift32(rng);
        stall       = (rng % 32'd100) < 32'd20;
        rng         = xorshift32(rng);
        flush       = (rng % 32'd100) < 32'd5;
        rng         = xorshift32(rng);
        fetch_addr  = rng;
        rng         = xorshift32(rng);
        decode_insn = rng;
    endtask

    task automatic drive_idle();
        fetch_valid = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        fetch_addr  = '0;
        decode_insn = '0;
    endtask

    // compare one strobe with the oldest expected record
    task automatic check_retire();
        retire_rec_t want;
        logic [31:0] span;
        if (retire_valid) begin
            if (exp_q.size() == 0) begin
                fail_run("retire strobe with no instruction left to retire");
            end else begin
                want = exp_q.pop_front();
                if (retired == 0) begin
                    check_value("first tag", 32'(retire_rec.tag), 32'd0);
                end
                check_value("tag", 32'(retire_rec.tag), 32'(want.tag));
                check_value("addr", retire_rec.addr, want.addr);
                check_value("insn", retire_rec.insn, want.insn);
                check_value("fetch cycle", retire_rec.fetch_cycle, want.fetch_cycle);
                check_value("retire cycle", retire_rec.retire_cycle, want.retire_cycle);
                check_value("fetch stalls", 32'(retire_rec.fetch_stalls),
                            32'(want.fetch_stalls));
                check_value("decode stalls", 32'(retire_rec.decode_stalls),
                            32'(want.decode_stalls));
                // latency is four edges plus every held cycle
                span = want.fetch_cycle + 32'd4 + 32'(want.fetch_stalls) +
                       32'(want.decode_stalls);
                check_value("latency", retire_rec.retire_cycle, span);
                retired++;
            end
        end
    endtask

    initial begin
        rst     = 1'b1;
        rng     = 32'h5510_937f;
        errors  = 0;
        retired = 0;
        drive_idle();
        model_reset();
        // strobe must stay low while in reset
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            check_value("retire_valid in reset", 32'(retire_valid), 32'd0);
        end
        rst = 1'b0;
        for (int n = 0; n < STIM_CYCLES + DRAIN_CYCLES; n++) begin
            if (n < STIM_CYCLES) begin
                drive_random();
            end else begin
                drive_idle();
            end
            @(negedge clk);
            check_retire();
            @(posedge clk);
            model_step(fetch_valid, fetch_addr, decode_insn, stall, flush);
            #1;
        end
        if (exp_q.size() != 0) begin
            fail_run("instructions never retired after the drain");
        end
        // several laps of the tag space
        if (retired <= 2 * TRACE_DEPTH) begin
            fail_run("too few records to cover the tag wrap");
        end
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    ////////////////////////////////
    // timeout
    ////////////////////////////////
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("FAILED: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $fatal(1, "timeout");
        end
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+test
hw/pipe_trace_pkg.sv
hw/stage_tag_pipe.sv
hw/stall_tally.sv
hw/trace_ram.sv
hw/retire_report.sv
hw/pipe_trace_top.sv
test/tb_pipe_trace.sv

/* Makefile */
# Verilator build and run for the pipeline trace monitor

VERILATOR ?= verilator
TOP       ?= tb_pipe_trace
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

PASS_MSG  := Done: no errors
FAIL_MSG  := Done: errors found

SRCS := $(wildcard hw/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
